// File: design/decode_macros.svh
// ==============================
// width and size macros for the decode stage
// include this file wherever a width or register count is needed
// ==============================
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// datapath and pc width
`define DATA_W 32

// register file addressing
`define REG_AW 5
`define NUM_REGS 32

// alu operation code carried to execute
`define ALUOP_W 6

`endif

// File: design/decode_pkg.sv
// ==============================
// shared types and encodings for the decode stage
// the instruction union gives R, I and J views of one word
// opcode, function, jump, load and branch codes live here
// ==============================
`default_nettype none

`include "decode_macros.svh"

package decode_pkg;

	// one instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			logic [`REG_AW-1:0] rs;
			logic [`REG_AW-1:0] rt;
			logic [`REG_AW-1:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] opcode;
			logic [`REG_AW-1:0] rs;
			logic [`REG_AW-1:0] rt;
			logic [15:0] imm;
		} i;
		struct packed {
			logic [5:0] opcode;
			logic [25:0] index;
		} j;
	} instr_u;

	// ==============================
	// opcodes
	// ==============================
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_REGIMM = 6'h01;
	localparam logic [5:0] OP_J = 6'h02;
	localparam logic [5:0] OP_JAL = 6'h03;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_ADDI = 6'h08;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_SLTI = 6'h0a;
	localparam logic [5:0] OP_SLTIU = 6'h0b;
	localparam logic [5:0] OP_ANDI = 6'h0c;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_XORI = 6'h0e;
	localparam logic [5:0] OP_LB = 6'h20;
	localparam logic [5:0] OP_LH = 6'h21;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;

	// R-type function codes
	localparam logic [5:0] FN_JR = 6'h08;
	localparam logic [5:0] FN_JALR = 6'h09;
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_NOR = 6'h27;
	localparam logic [5:0] FN_SLT = 6'h2a;
	localparam logic [5:0] FN_SLTU = 6'h2b;

	// jump kinds
	localparam logic [1:0] JMP_NONE = 2'd0;
	localparam logic [1:0] JMP_IMM = 2'd1;
	localparam logic [1:0] JMP_REG = 2'd2;

	// load sizes
	localparam logic [1:0] LD_WORD = 2'd0;
	localparam logic [1:0] LD_HALF = 2'd1;
	localparam logic [1:0] LD_BYTE = 2'd2;

	// branch operations, none means not a branch
	localparam logic [2:0] BOP_NONE = 3'd0;
	localparam logic [2:0] BOP_BEQ = 3'd1;
	localparam logic [2:0] BOP_BNE = 3'd2;
	localparam logic [2:0] BOP_BLTZ = 3'd3;
	localparam logic [2:0] BOP_BGEZ = 3'd4;

endpackage

`default_nettype wire

// File: design/fetch_if.sv
// ==============================
// buffered instruction link from the input buffer to decode
// valid/ready handshake plus instruction and PC+4
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

interface fetch_if import decode_pkg::*; ();

	logic valid;
	logic ready;
	instr_u instr;
	logic [`DATA_W-1:0] pc4;

	// buffer side
	modport src (output valid, output instr, output pc4, input ready);

	// decode side
	modport sink (input valid, input instr, input pc4, output ready);

endinterface

`default_nettype wire

// File: design/idex_if.sv
// ==============================
// decoded bundle from the decode core to the ID/EX register
// operands, controls and targets with a valid/ready handshake
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

interface idex_if ();

	logic valid;
	logic ready;

	// operands and register addresses
	logic [`DATA_W-1:0] rs_data;
	logic [`DATA_W-1:0] rt_data;
	logic [`REG_AW-1:0] rs;
	logic [`REG_AW-1:0] rt;
	logic [`REG_AW-1:0] rd;
	logic [`DATA_W-1:0] pc4;
	logic [`DATA_W-1:0] imm_ext;

	// datapath controls
	logic [`ALUOP_W-1:0] aluop;
	logic alusrc;
	logic regdst;
	logic memread;
	logic memwrite;
	logic [1:0] loadsize;
	logic memtoreg;
	logic regwrite;
	logic link;

	// control flow
	logic branch_taken;
	logic [1:0] jump_kind;
	logic [`DATA_W-1:0] branch_target;
	logic [`DATA_W-1:0] jump_target;
	logic illegal;

	modport src (
		output valid, rs_data, rt_data, rs, rt, rd, pc4, imm_ext,
		output aluop, alusrc, regdst, memread, memwrite, loadsize, memtoreg, regwrite, link,
		output branch_taken, jump_kind, branch_target, jump_target, illegal,
		input ready
	);

	modport sink (
		input valid, rs_data, rt_data, rs, rt, rd, pc4, imm_ext,
		input aluop, alusrc, regdst, memread, memwrite, loadsize, memtoreg, regwrite, link,
		input branch_taken, jump_kind, branch_target, jump_target, illegal,
		output ready
	);

endinterface

`default_nettype wire

// File: design/fetch_buffer.sv
// ==============================
// one-entry input buffer for instruction and PC+4
// accepts when empty or when its entry leaves the same cycle
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module fetch_buffer import decode_pkg::*; (
	input wire i_clk,
	input wire i_nrst,
	input wire i_in_valid,
	output logic o_in_ready,
	input wire instr_u i_in_instr,
	input wire [`DATA_W-1:0] i_in_pc4,
	fetch_if.src o_fetch
);

	logic valid_q;
	instr_u instr_q;
	logic [`DATA_W-1:0] pc4_q;
	logic load;

	// free slot, or the entry is leaving now
	assign o_in_ready = !valid_q || o_fetch.ready;
	assign load = i_in_valid && o_in_ready;

	always_ff @(posedge i_clk or negedge i_nrst) begin
		if (!i_nrst) begin
			valid_q <= 1'b0;
		end else if (load) begin
			valid_q <= 1'b1;
		end else if (o_fetch.ready) begin
			valid_q <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (load) begin
			instr_q <= i_in_instr;
			pc4_q <= i_in_pc4;
		end
	end

	assign o_fetch.valid = valid_q;
	assign o_fetch.instr = instr_q;
	assign o_fetch.pc4 = pc4_q;

	// fetch keeps its instruction until the buffer takes it
	a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
		(i_in_valid && !o_in_ready) |=>
		(i_in_valid && $stable(i_in_instr) && $stable(i_in_pc4)));

endmodule

`default_nettype wire

// File: design/instr_decoder.sv
// ==============================
// control decode from opcode, funct and rt bit 16
// produces datapath controls, jump kind and branch operation
// unknown encodings give zero controls with illegal set
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module instr_decoder import decode_pkg::*; (
	input wire instr_u i_instr,
	output logic [`ALUOP_W-1:0] o_aluop,
	output logic o_alusrc,
	output logic o_regdst,
	output logic o_memread,
	output logic o_memwrite,
	output logic [1:0] o_loadsize,
	output logic o_memtoreg,
	output logic o_regwrite,
	output logic o_link,
	output logic o_signext,
	output logic [1:0] o_jump_kind,
	output logic [2:0] o_bop,
	output logic o_illegal
);

	always_comb begin
		o_aluop = i_instr.r.opcode;
		o_alusrc = 1'b0;
		o_regdst = 1'b0;
		o_memread = 1'b0;
		o_memwrite = 1'b0;
		o_loadsize = LD_WORD;
		o_memtoreg = 1'b0;
		o_regwrite = 1'b0;
		o_link = 1'b0;
		o_signext = 1'b1;
		o_jump_kind = JMP_NONE;
		o_bop = BOP_NONE;
		o_illegal = 1'b0;

		case (i_instr.r.opcode)
			OP_RTYPE: begin
				o_aluop = i_instr.r.funct;
				o_regdst = 1'b1;
				case (i_instr.r.funct)
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
					FN_XOR, FN_NOR, FN_SLT, FN_SLTU: o_regwrite = 1'b1;
					FN_JR: o_jump_kind = JMP_REG;
					FN_JALR: begin
						o_jump_kind = JMP_REG;
						o_regwrite = 1'b1;
						o_link = 1'b1;
					end
					default: o_illegal = 1'b1;
				endcase
			end
			// bit 16 picks bgez over bltz
			OP_REGIMM: o_bop = i_instr.i.rt[0] ? BOP_BGEZ : BOP_BLTZ;
			OP_BEQ: o_bop = BOP_BEQ;
			OP_BNE: o_bop = BOP_BNE;
			OP_J: o_jump_kind = JMP_IMM;
			OP_JAL: begin
				o_jump_kind = JMP_IMM;
				o_regwrite = 1'b1;
				o_link = 1'b1;
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				o_alusrc = 1'b1;
				o_regwrite = 1'b1;
			end
			// logical immediates are zero-extended
			OP_ANDI, OP_ORI, OP_XORI: begin
				o_alusrc = 1'b1;
				o_regwrite = 1'b1;
				o_signext = 1'b0;
			end
			OP_LW, OP_LH, OP_LB: begin
				o_alusrc = 1'b1;
				o_memread = 1'b1;
				o_memtoreg = 1'b1;
				o_regwrite = 1'b1;
				case (i_instr.r.opcode)
					OP_LH: o_loadsize = LD_HALF;
					OP_LB: o_loadsize = LD_BYTE;
					default: o_loadsize = LD_WORD;
				endcase
			end
			OP_SW: begin
				o_alusrc = 1'b1;
				o_memwrite = 1'b1;
			end
			default: o_illegal = 1'b1;
		endcase

		// illegal wipes everything else
		if (o_illegal) begin
			o_aluop = '0;
			o_alusrc = 1'b0;
			o_regdst = 1'b0;
			o_memread = 1'b0;
			o_memwrite = 1'b0;
			o_loadsize = LD_WORD;
			o_memtoreg = 1'b0;
			o_regwrite = 1'b0;
			o_link = 1'b0;
			o_signext = 1'b0;
			o_jump_kind = JMP_NONE;
			o_bop = BOP_NONE;
		end
	end

endmodule

`default_nettype wire

// File: design/register_bank.sv
// ==============================
// 32 x 32 register file, two read ports and one write port
// reads are combinational with write-through on a match
// register 0 is never written and reads as zero
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module register_bank (
	input wire i_clk,
	input wire i_nrst,
	input wire [`REG_AW-1:0] i_rs,
	input wire [`REG_AW-1:0] i_rt,
	input wire i_we,
	input wire [`REG_AW-1:0] i_waddr,
	input wire [`DATA_W-1:0] i_wdata,
	output logic [`DATA_W-1:0] o_rs_data,
	output logic [`DATA_W-1:0] o_rt_data
);

	logic [`DATA_W-1:0] regs [`NUM_REGS];

	always_ff @(posedge i_clk or negedge i_nrst) begin
		if (!i_nrst) begin
			for (int k = 0; k < `NUM_REGS; k++) begin
				regs[k] <= '0;
			end
		end else if (i_we && i_waddr != '0) begin
			regs[i_waddr] <= i_wdata;
		end
	end

	// bypass the write in flight, never for r0
	assign o_rs_data = (i_we && i_waddr == i_rs && i_rs != '0) ? i_wdata : regs[i_rs];
	assign o_rt_data = (i_we && i_waddr == i_rt && i_rt != '0) ? i_wdata : regs[i_rt];

	// r0 stays zero across any write history
	a_zero_reg: assert property (@(posedge i_clk) disable iff (!i_nrst)
		(i_rs != '0 || o_rs_data == '0) && (i_rt != '0 || o_rt_data == '0));

endmodule

`default_nettype wire

// File: design/decode_core.sv
// ==============================
// combinational decode of the buffered instruction
// register reads, branch compare, immediate and target generation
// handshake passes straight through to the ID/EX register
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module decode_core import decode_pkg::*; (
	input wire i_clk,
	input wire i_nrst,
	input wire i_wb_en,
	input wire [`REG_AW-1:0] i_wb_addr,
	input wire [`DATA_W-1:0] i_wb_data,
	fetch_if.sink i_fetch,
	idex_if.src o_idex
);

	logic [2:0] bop;
	logic signext;
	logic [`DATA_W-1:0] rs_data;
	logic [`DATA_W-1:0] rt_data;
	logic [15:0] imm;
	logic cond;

	instr_decoder u_decoder (
		.i_instr(i_fetch.instr),
		.o_aluop(o_idex.aluop),
		.o_alusrc(o_idex.alusrc),
		.o_regdst(o_idex.regdst),
		.o_memread(o_idex.memread),
		.o_memwrite(o_idex.memwrite),
		.o_loadsize(o_idex.loadsize),
		.o_memtoreg(o_idex.memtoreg),
		.o_regwrite(o_idex.regwrite),
		.o_link(o_idex.link),
		.o_signext(signext),
		.o_jump_kind(o_idex.jump_kind),
		.o_bop(bop),
		.o_illegal(o_idex.illegal)
	);

	register_bank u_regs (
		.i_clk(i_clk),
		.i_nrst(i_nrst),
		.i_rs(i_fetch.instr.r.rs),
		.i_rt(i_fetch.instr.r.rt),
		.i_we(i_wb_en),
		.i_waddr(i_wb_addr),
		.i_wdata(i_wb_data),
		.o_rs_data(rs_data),
		.o_rt_data(rt_data)
	);

	// ==============================
	// branch resolution
	// ==============================
	always_comb begin
		case (bop)
			BOP_BEQ: cond = (rs_data == rt_data);
			BOP_BNE: cond = (rs_data != rt_data);
			BOP_BLTZ: cond = rs_data[`DATA_W-1];
			BOP_BGEZ: cond = !rs_data[`DATA_W-1];
			default: cond = 1'b0;
		endcase
	end

	assign imm = i_fetch.instr.i.imm;

	assign o_idex.valid = i_fetch.valid;
	assign i_fetch.ready = o_idex.ready;
	assign o_idex.rs_data = rs_data;
	assign o_idex.rt_data = rt_data;
	assign o_idex.rs = i_fetch.instr.r.rs;
	assign o_idex.rt = i_fetch.instr.r.rt;
	assign o_idex.rd = i_fetch.instr.r.rd;
	assign o_idex.pc4 = i_fetch.pc4;
	assign o_idex.imm_ext = signext ? {{(`DATA_W-16){imm[15]}}, imm} : {{(`DATA_W-16){1'b0}}, imm};
	assign o_idex.branch_taken = cond;

	// word offset from PC+4
	assign o_idex.branch_target = i_fetch.pc4 + {{(`DATA_W-18){imm[15]}}, imm, 2'b00};
	// region bits of PC+4 above the index
	assign o_idex.jump_target = {i_fetch.pc4[`DATA_W-1:`DATA_W-4], i_fetch.instr.j.index, 2'b00};

endmodule

`default_nettype wire

// File: design/idex_register.sv
// ==============================
// ID/EX pipeline register toward execute
// loads a new bundle when empty or when execute takes the current one
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module idex_register (
	input wire i_clk,
	input wire i_nrst,
	idex_if.sink i_idex,
	output logic o_ex_valid,
	input wire i_ex_ready,
	output logic [`DATA_W-1:0] o_rs_data,
	output logic [`DATA_W-1:0] o_rt_data,
	output logic [`REG_AW-1:0] o_rs,
	output logic [`REG_AW-1:0] o_rt,
	output logic [`REG_AW-1:0] o_rd,
	output logic [`DATA_W-1:0] o_pc4,
	output logic [`DATA_W-1:0] o_imm_ext,
	output logic [`ALUOP_W-1:0] o_aluop,
	output logic o_alusrc,
	output logic o_regdst,
	output logic o_memread,
	output logic o_memwrite,
	output logic [1:0] o_loadsize,
	output logic o_memtoreg,
	output logic o_regwrite,
	output logic o_link,
	output logic o_branch_taken,
	output logic [1:0] o_jump_kind,
	output logic [`DATA_W-1:0] o_branch_target,
	output logic [`DATA_W-1:0] o_jump_target,
	output logic o_illegal
);

	// six data words, three reg addresses, aluop, 13 control bits
	localparam int BUNDLE_W = 6 * `DATA_W + 3 * `REG_AW + `ALUOP_W + 13;

	logic [BUNDLE_W-1:0] bundle_q;
	logic load;

	assign i_idex.ready = !o_ex_valid || i_ex_ready;
	assign load = i_idex.ready && i_idex.valid;

	always_ff @(posedge i_clk or negedge i_nrst) begin
		if (!i_nrst) begin
			o_ex_valid <= 1'b0;
		end else if (i_idex.ready) begin
			o_ex_valid <= i_idex.valid;
		end
	end

	always_ff @(posedge i_clk or negedge i_nrst) begin
		if (!i_nrst) begin
			bundle_q <= '0;
		end else if (load) begin
			bundle_q <= {i_idex.rs_data, i_idex.rt_data, i_idex.rs, i_idex.rt, i_idex.rd,
				i_idex.pc4, i_idex.imm_ext, i_idex.aluop, i_idex.alusrc, i_idex.regdst,
				i_idex.memread, i_idex.memwrite, i_idex.loadsize, i_idex.memtoreg,
				i_idex.regwrite, i_idex.link, i_idex.branch_taken, i_idex.jump_kind,
				i_idex.branch_target, i_idex.jump_target, i_idex.illegal};
		end
	end

	assign {o_rs_data, o_rt_data, o_rs, o_rt, o_rd, o_pc4, o_imm_ext, o_aluop, o_alusrc,
		o_regdst, o_memread, o_memwrite, o_loadsize, o_memtoreg, o_regwrite, o_link,
		o_branch_taken, o_jump_kind, o_branch_target, o_jump_target, o_illegal} = bundle_q;

	a_valid_known: assert property (@(posedge i_clk) disable iff (!i_nrst)
		!$isunknown(o_ex_valid));

	// stalled output keeps its payload until taken
	a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_nrst)
		(o_ex_valid && !i_ex_ready) |=> (o_ex_valid && $stable(bundle_q)));

endmodule

`default_nettype wire

// File: design/decode_stage.sv
// ==============================
// instruction decode stage, top level
// input buffer, decode core and ID/EX register joined by two interfaces
// two cycles from input transfer to output valid, one per cycle throughput
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module decode_stage (
	input wire i_clk,
	input wire i_nrst,
	// fetch side
	input wire i_in_valid,
	output logic o_in_ready,
	input wire [`DATA_W-1:0] i_in_instr,
	input wire [`DATA_W-1:0] i_in_pc4,
	// writeback port
	input wire i_wb_en,
	input wire [`REG_AW-1:0] i_wb_addr,
	input wire [`DATA_W-1:0] i_wb_data,
	// execute side
	output logic o_ex_valid,
	input wire i_ex_ready,
	output logic [`DATA_W-1:0] o_rs_data,
	output logic [`DATA_W-1:0] o_rt_data,
	output logic [`REG_AW-1:0] o_rs,
	output logic [`REG_AW-1:0] o_rt,
	output logic [`REG_AW-1:0] o_rd,
	output logic [`DATA_W-1:0] o_pc4,
	output logic [`DATA_W-1:0] o_imm_ext,
	output logic [`ALUOP_W-1:0] o_aluop,
	output logic o_alusrc,
	output logic o_regdst,
	output logic o_memread,
	output logic o_memwrite,
	output logic [1:0] o_loadsize,
	output logic o_memtoreg,
	output logic o_regwrite,
	output logic o_link,
	output logic o_branch_taken,
	output logic [1:0] o_jump_kind,
	output logic [`DATA_W-1:0] o_branch_target,
	output logic [`DATA_W-1:0] o_jump_target,
	output logic o_illegal
);

	fetch_if fetch_bus ();
	idex_if idex_bus ();

	fetch_buffer u_fetch_buffer (
		.i_clk(i_clk),
		.i_nrst(i_nrst),
		.i_in_valid(i_in_valid),
		.o_in_ready(o_in_ready),
		.i_in_instr(i_in_instr),
		.i_in_pc4(i_in_pc4),
		.o_fetch(fetch_bus)
	);

	decode_core u_decode_core (
		.i_clk(i_clk),
		.i_nrst(i_nrst),
		.i_wb_en(i_wb_en),
		.i_wb_addr(i_wb_addr),
		.i_wb_data(i_wb_data),
		.i_fetch(fetch_bus),
		.o_idex(idex_bus)
	);

	// output ports share names with the register ports
	idex_register u_idex_register (
		.i_idex(idex_bus),
		.*
	);

endmodule

`default_nettype wire

// File: testbench/tb_decode_stage.sv
// ==============================
// testbench for the instruction decode stage
// drives random and directed instructions, models the register file,
// predicts every ID/EX bundle and compares each cycle the output is valid
// ==============================
`timescale 1ns/1ps
`default_nettype none

`include "decode_macros.svh"

module tb_decode_stage import decode_pkg::*; ();

	localparam int N_RAND = 150;
	localparam int N_MIX = 300;
	localparam int STIM_CYCLES = 2 * `NUM_REGS + N_RAND + 60 + 6 * N_MIX + 300;
	localparam int TIMEOUT_NS = 2 * STIM_CYCLES * 20 + 2000;

	localparam logic [5:0] ALU_FN [10] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND,
		FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
	localparam logic [5:0] IMM_OP [7] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
		OP_ORI, OP_XORI};
	localparam logic [5:0] MEM_OP [4] = '{OP_LW, OP_LH, OP_LB, OP_SW};
	localparam logic [5:0] BR_OP [3] = '{OP_BEQ, OP_BNE, OP_REGIMM};
	localparam logic [5:0] ILL_OP [8] = '{6'h06, 6'h07, 6'h0f, 6'h10, 6'h22, 6'h24,
		6'h28, 6'h3f};
	localparam logic [5:0] ILL_FN [6] = '{6'h00, 6'h02, 6'h18, 6'h1a, 6'h2c, 6'h3f};

	typedef struct packed {
		logic [`DATA_W-1:0] rs_data;
		logic [`DATA_W-1:0] rt_data;
		logic [`REG_AW-1:0] rs;
		logic [`REG_AW-1:0] rt;
		logic [`REG_AW-1:0] rd;
		logic [`DATA_W-1:0] pc4;
		logic [`DATA_W-1:0] imm_ext;
		logic [`ALUOP_W-1:0] aluop;
		logic alusrc;
		logic regdst;
		logic memread;
		logic memwrite;
		logic [1:0] loadsize;
		logic memtoreg;
		logic regwrite;
		logic link;
		logic branch_taken;
		logic [1:0] jump_kind;
		logic [`DATA_W-1:0] branch_target;
		logic [`DATA_W-1:0] jump_target;
		logic illegal;
	} exp_t;

	logic i_clk;
	logic i_nrst;
	logic i_in_valid;
	logic o_in_ready;
	logic [`DATA_W-1:0] i_in_instr;
	logic [`DATA_W-1:0] i_in_pc4;
	logic i_wb_en;
	logic [`REG_AW-1:0] i_wb_addr;
	logic [`DATA_W-1:0] i_wb_data;
	logic o_ex_valid;
	logic i_ex_ready;
	logic [`DATA_W-1:0] o_rs_data;
	logic [`DATA_W-1:0] o_rt_data;
	logic [`REG_AW-1:0] o_rs;
	logic [`REG_AW-1:0] o_rt;
	logic [`REG_AW-1:0] o_rd;
	logic [`DATA_W-1:0] o_pc4;
	logic [`DATA_W-1:0] o_imm_ext;
	logic [`ALUOP_W-1:0] o_aluop;
	logic o_alusrc;
	logic o_regdst;
	logic o_memread;
	logic o_memwrite;
	logic [1:0] o_loadsize;
	logic o_memtoreg;
	logic o_regwrite;
	logic o_link;
	logic o_branch_taken;
	logic [1:0] o_jump_kind;
	logic [`DATA_W-1:0] o_branch_target;
	logic [`DATA_W-1:0] o_jump_target;
	logic o_illegal;

	logic [31:0] rng_state = 32'h6fb8b8cf;
	logic [`DATA_W-1:0] model [`NUM_REGS];
	exp_t exp_q [$];
	int stamp_q [$];
	int errors = 0;
	int n_in = 0;
	int n_out = 0;
	int cyc = 0;
	bit bp_on = 1'b0;

	decode_stage uut (.*);

	initial begin
		i_clk = 1'b0;
		forever #10 i_clk = ~i_clk;
	end

	always @(posedge i_clk) cyc <= cyc + 1;

	// ==============================
	// helpers
	// ==============================
	function automatic logic [31:0] rnd();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic logic [15:0] rnd16();
		logic [31:0] r;
		r = rnd();
		return r[31:16];
	endfunction

	function automatic logic [31:0] rnd_pc();
		return rnd() & 32'hfffffffc;
	endfunction

	function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
			input logic [4:0] rd, input logic [5:0] fn);
		return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// kinds 0..2 are datapath only, 3..5 add branches and jumps
	function automatic logic [31:0] random_instr(input bit with_flow);
		logic [31:0] r;
		logic [31:0] w;
		int kind;
		int k;
		r = rnd();
		kind = with_flow ? int'(rnd() % 6) : int'(rnd() % 3);
		k = int'(rnd() % 10);
		case (kind)
			0: w = r_word(r[4:0], r[9:5], r[14:10], ALU_FN[k]);
			1: w = i_word(IMM_OP[k % 7], r[4:0], r[9:5], r[31:16]);
			2: w = i_word(MEM_OP[k % 4], r[4:0], r[9:5], r[31:16]);
			3: w = i_word(BR_OP[k % 3], r[4:0], r[9:5], r[31:16]);
			4: w = {(r[0] ? OP_JAL : OP_J), r[31:6]};
			default: w = r_word(r[4:0], 5'd0, r[14:10], r[15] ? FN_JALR : FN_JR);
		endcase
		return w;
	endfunction

	// expected bundle from the decode rules
	// a and b carry the rs and rt register values
	function automatic exp_t ref_decode(input logic [31:0] w, input logic [31:0] pc4,
			input logic [31:0] a, input logic [31:0] b);
		exp_t e;
		logic sx;
		logic [5:0] op;
		logic [5:0] fn;
		logic [31:0] simm;
		op = w[31:26];
		fn = w[5:0];
		e = '0;
		sx = 1'b1;
		e.aluop = op;
		case (op)
			OP_RTYPE: begin
				e.aluop = fn;
				e.regdst = 1'b1;
				if (fn == FN_JR || fn == FN_JALR) begin
					e.jump_kind = JMP_REG;
					e.regwrite = (fn == FN_JALR);
					e.link = (fn == FN_JALR);
				end else if (fn inside {FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR,
						FN_XOR, FN_NOR, FN_SLT, FN_SLTU}) begin
					e.regwrite = 1'b1;
				end else begin
					e.illegal = 1'b1;
				end
			end
			// rt bit 0 set means bgez
			OP_REGIMM: e.branch_taken = w[16] ? !a[31] : a[31];
			OP_BEQ: e.branch_taken = (a == b);
			OP_BNE: e.branch_taken = (a != b);
			OP_J: e.jump_kind = JMP_IMM;
			OP_JAL: begin
				e.jump_kind = JMP_IMM;
				e.regwrite = 1'b1;
				e.link = 1'b1;
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				e.alusrc = 1'b1;
				e.regwrite = 1'b1;
			end
			OP_ANDI, OP_ORI, OP_XORI: begin
				e.alusrc = 1'b1;
				e.regwrite = 1'b1;
				sx = 1'b0;
			end
			OP_LW, OP_LH, OP_LB: begin
				e.alusrc = 1'b1;
				e.memread = 1'b1;
				e.memtoreg = 1'b1;
				e.regwrite = 1'b1;
				e.loadsize = (op == OP_LH) ? LD_HALF : (op == OP_LB) ? LD_BYTE : LD_WORD;
			end
			OP_SW: begin
				e.alusrc = 1'b1;
				e.memwrite = 1'b1;
			end
			default: e.illegal = 1'b1;
		endcase
		if (e.illegal) begin
			e = '0;
			e.illegal = 1'b1;
			sx = 1'b0;
		end
		simm = {{16{w[15]}}, w[15:0]};
		e.rs = w[25:21];
		e.rt = w[20:16];
		e.rd = w[15:11];
		e.rs_data = a;
		e.rt_data = b;
		e.pc4 = pc4;
		e.imm_ext = sx ? simm : {16'b0, w[15:0]};
		// word offset counted in instructions
		e.branch_target = pc4 + simm * 4;
		e.jump_target = {pc4[31:28], w[25:0], 2'b00};
		return e;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		if (got !== want) begin
			$display("Fail %0t %s got %h expected %h", $time, name, got, want);
			errors++;
		end
	endtask

	task automatic compare_outputs(input exp_t e);
		check_value("o_rs_data", o_rs_data, e.rs_data);
		check_value("o_rt_data", o_rt_data, e.rt_data);
		check_value("o_rs", 32'(o_rs), 32'(e.rs));
		check_value("o_rt", 32'(o_rt), 32'(e.rt));
		check_value("o_rd", 32'(o_rd), 32'(e.rd));
		check_value("o_pc4", o_pc4, e.pc4);
		check_value("o_imm_ext", o_imm_ext, e.imm_ext);
		check_value("o_aluop", 32'(o_aluop), 32'(e.aluop));
		check_value("o_alusrc", 32'(o_alusrc), 32'(e.alusrc));
		check_value("o_regdst", 32'(o_regdst), 32'(e.regdst));
		check_value("o_memread", 32'(o_memread), 32'(e.memread));
		check_value("o_memwrite", 32'(o_memwrite), 32'(e.memwrite));
		check_value("o_loadsize", 32'(o_loadsize), 32'(e.loadsize));
		check_value("o_memtoreg", 32'(o_memtoreg), 32'(e.memtoreg));
		check_value("o_regwrite", 32'(o_regwrite), 32'(e.regwrite));
		check_value("o_link", 32'(o_link), 32'(e.link));
		check_value("o_branch_taken", 32'(o_branch_taken), 32'(e.branch_taken));
		check_value("o_jump_kind", 32'(o_jump_kind), 32'(e.jump_kind));
		check_value("o_branch_target", o_branch_target, e.branch_target);
		check_value("o_jump_target", o_jump_target, e.jump_target);
		check_value("o_illegal", 32'(o_illegal), 32'(e.illegal));
	endtask

	// ==============================
	// stimulus tasks
	// ==============================
	task automatic shake_ready();
		i_ex_ready = bp_on ? (rnd() % 3 != 0) : 1'b1;
	endtask

	task automatic push_expected(input logic [31:0] w, input logic [31:0] pc4);
		exp_q.push_back(ref_decode(w, pc4, model[w[25:21]], model[w[20:16]]));
		stamp_q.push_back(bp_on ? -1 : cyc);
		n_in++;
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge i_clk);
			i_in_valid = 1'b0;
			i_wb_en = 1'b0;
			shake_ready();
		end
	endtask

	// holds valid until the stage takes the instruction
	task automatic send(input logic [31:0] w, input logic [31:0] pc4);
		@(negedge i_clk);
		i_in_valid = 1'b1;
		i_in_instr = w;
		i_in_pc4 = pc4;
		i_wb_en = 1'b0;
		shake_ready();
		@(posedge i_clk);
		while (!o_in_ready) begin
			@(negedge i_clk);
			shake_ready();
			@(posedge i_clk);
		end
		push_expected(w, pc4);
	endtask

	task automatic write_reg(input logic [4:0] a, input logic [31:0] d);
		@(negedge i_clk);
		i_in_valid = 1'b0;
		i_wb_en = 1'b1;
		i_wb_addr = a;
		i_wb_data = d;
		if (a != 5'd0) model[a] = d;
	endtask

	// write lands in the cycle the instruction moves into ID/EX
	task automatic send_with_write(input logic [31:0] w, input logic [31:0] pc4,
			input logic [4:0] waddr, input logic [31:0] wdata);
		@(negedge i_clk);
		i_in_valid = 1'b1;
		i_in_instr = w;
		i_in_pc4 = pc4;
		i_wb_en = 1'b0;
		@(posedge i_clk);
		if (!o_in_ready) begin
			$display("instruction not accepted by a free stage at %0t", $time);
			errors++;
		end
		if (waddr != 5'd0) model[waddr] = wdata;
		push_expected(w, pc4);
		@(negedge i_clk);
		i_in_valid = 1'b0;
		i_wb_en = 1'b1;
		i_wb_addr = waddr;
		i_wb_data = wdata;
	endtask

	task automatic drain();
		int k;
		k = 0;
		while (exp_q.size() != 0 && k < 50) begin
			idle(1);
			k++;
		end
		if (exp_q.size() != 0) begin
			$display("%0d instructions never left the stage by %0t", exp_q.size(), $time);
			errors++;
			exp_q.delete();
			stamp_q.delete();
		end
	endtask

	// ==============================
	// output checker for every valid output cycle
	// ==============================
	always @(posedge i_clk) begin
		if (i_nrst && o_ex_valid) begin
			if (exp_q.size() == 0) begin
				$display("output valid at %0t with no instruction outstanding", $time);
				errors++;
			end else begin
				compare_outputs(exp_q[0]);
				if (i_ex_ready) begin
					if (stamp_q[0] >= 0) check_value("latency", 32'(cyc - stamp_q[0]), 32'd2);
					void'(exp_q.pop_front());
					void'(stamp_q.pop_front());
					n_out++;
				end
			end
		end
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout at %0t after %0d instructions in, %0d errors", $time, n_in, errors);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		logic [31:0] r;
		for (int k = 0; k < `NUM_REGS; k++) model[k] = '0;
		i_nrst = 1'b0;
		i_in_valid = 1'b0;
		i_in_instr = '0;
		i_in_pc4 = '0;
		i_wb_en = 1'b0;
		i_wb_addr = '0;
		i_wb_data = '0;
		i_ex_ready = 1'b1;
		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		i_nrst = 1'b1;

		// state right after reset
		check_value("o_ex_valid", 32'(o_ex_valid), 32'd0);
		check_value("o_in_ready", 32'(o_in_ready), 32'd1);
		check_value("controls", 32'({o_aluop, o_alusrc, o_regdst, o_memread, o_memwrite,
			o_loadsize, o_memtoreg, o_regwrite, o_link, o_branch_taken, o_jump_kind,
			o_illegal}), 32'd0);

		// random register contents, then back-to-back datapath instructions
		for (int k = 1; k < `NUM_REGS; k++) write_reg(5'(k), rnd());
		for (int k = 0; k < N_RAND; k++) send(random_instr(1'b0), rnd_pc());
		drain();

		// branches both ways, then jumps
		write_reg(5'd1, 32'd5);
		write_reg(5'd2, 32'd5);
		write_reg(5'd3, 32'd7);
		write_reg(5'd4, 32'hfffffffd);
		write_reg(5'd5, 32'd0);
		send(i_word(OP_BEQ, 5'd1, 5'd2, rnd16()), rnd_pc());
		send(i_word(OP_BEQ, 5'd1, 5'd3, rnd16()), rnd_pc());
		send(i_word(OP_BNE, 5'd1, 5'd3, rnd16()), rnd_pc());
		send(i_word(OP_BNE, 5'd1, 5'd2, rnd16()), rnd_pc());
		send(i_word(OP_REGIMM, 5'd4, 5'd0, rnd16()), rnd_pc());
		send(i_word(OP_REGIMM, 5'd1, 5'd0, rnd16()), rnd_pc());
		send(i_word(OP_REGIMM, 5'd1, 5'd1, rnd16()), rnd_pc());
		send(i_word(OP_REGIMM, 5'd4, 5'd1, rnd16()), rnd_pc());
		send(i_word(OP_REGIMM, 5'd5, 5'd17, rnd16()), rnd_pc());
		r = rnd();
		send({OP_J, r[25:0]}, rnd_pc());
		send({OP_JAL, r[31:6]}, rnd_pc());
		send(r_word(5'd3, 5'd0, 5'd0, FN_JR), rnd_pc());
		send(r_word(5'd3, 5'd0, 5'd31, FN_JALR), rnd_pc());
		drain();

		// random traffic with gaps and a stalling execute stage
		bp_on = 1'b1;
		for (int k = 0; k < N_MIX; k++) begin
			if (rnd() % 4 == 0) idle(int'(rnd() % 3) + 1);
			send(random_instr(1'b1), rnd_pc());
		end
		bp_on = 1'b0;
		drain();

		// same-cycle writeback on rs, then on rt
		write_reg(5'd7, rnd());
		write_reg(5'd9, rnd());
		send_with_write(r_word(5'd7, 5'd9, 5'd3, FN_ADDU), rnd_pc(), 5'd7, rnd());
		send_with_write(r_word(5'd9, 5'd7, 5'd4, FN_SUB), rnd_pc(), 5'd7, rnd());
		// r0 ignores writes, plain and same-cycle
		write_reg(5'd0, rnd());
		send(r_word(5'd0, 5'd0, 5'd5, FN_OR), rnd_pc());
		send_with_write(i_word(OP_SW, 5'd0, 5'd0, rnd16()), rnd_pc(), 5'd0, 32'hffffffff);
		drain();

		// undefined opcodes and function codes
		for (int k = 0; k < 8; k++) begin
			r = rnd();
			send({ILL_OP[k], r[25:0]}, rnd_pc());
		end
		for (int k = 0; k < 6; k++) begin
			r = rnd();
			send({OP_RTYPE, r[25:6], ILL_FN[k]}, rnd_pc());
		end
		drain();

		idle(4);
		check_value("instructions out", 32'(n_out), 32'(n_in));
		$display("errors %0d, instructions in %0d, out %0d", errors, n_in, n_out);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: decode_stage.f
+incdir+design
design/decode_pkg.sv
design/fetch_if.sv
design/idex_if.sv
design/fetch_buffer.sv
design/instr_decoder.sv
design/register_bank.sv
design/decode_core.sv
design/idex_register.sv
design/decode_stage.sv
testbench/tb_decode_stage.sv

// File: run_sim.sh
#!/bin/sh
# build the decode stage testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	-f decode_stage.f \
	--top-module tb_decode_stage \
	--Mdir obj_dir -o sim_decode_stage || exit 1

out=$(./obj_dir/sim_decode_stage)
echo "$out"
echo "$out" | grep -q "^ALL CHECKS PASSED$" && exit 0 || exit 1
